/* src/sdmacBusPkg.sv */
// SCSI DMA bus definitions
// Memory bus and APB types, register map and bus-master state encoding
package sdmacBusPkg;

    // Data longword, same width on APB and memory bus
    typedef logic [31:0] longT;
    // Longword address, byte address without bits 1:0
    typedef logic [29:0] addrT;
    // Transfer length counted in longwords
    typedef logic [15:0] countT;
    // APB byte offset into the register block
    typedef logic [3:0] regAddrT;

    // Register map
    localparam regAddrT regAddr = 4'h0;
    localparam regAddrT regCount = 4'h4;
    localparam regAddrT regCtrl = 4'h8;
    localparam regAddrT regStatus = 4'hC;

    // Control register bits, dir set means memory to SCSI
    localparam int ctrlStart = 0;
    localparam int ctrlDir = 1;

    // APB request from the host, zero-wait slave
    typedef struct packed {
        logic psel;
        logic penable;
        logic pwrite;
        regAddrT paddr;
        longT pwdata;
    } apbReqT;

    // Memory bus cycle driven by the DMA master
    typedef struct packed {
        logic addrStrobe;
        logic write;
        addrT addr;
        longT wdata;
    } memReqT;

    // Memory slave response, termAck is a single-cycle pulse
    typedef struct packed {
        logic busGrant;
        logic termAck;
        longT rdata;
    } memRspT;

    // Bus-master states
    typedef enum logic [1:0] {
        idle,
        request,
        strobe,
        advance
    } busStateT;

endpackage

/* src/sdmacFifoPkg.sv */
// SCSI DMA FIFO definitions
// Depth, pointer and lane types, and the status flags seen by both sides
package sdmacFifoPkg;

    // Depth in longwords
    localparam int fifoDepth = 8;
    // Byte lanes per longword
    localparam int laneCount = 4;

    // One SCSI data byte
    typedef logic [7:0] byteT;
    // Word slot index
    typedef logic [$clog2(fifoDepth)-1:0] ptrT;
    // Byte lane inside a longword, lane 0 is least significant
    typedef logic [$clog2(laneCount)-1:0] laneT;
    // Occupancy in longwords, 0 up to fifoDepth
    typedef logic [$clog2(fifoDepth+1)-1:0] occT;

    // Occupancy of a full FIFO
    localparam occT occFull = occT'(fifoDepth);
    // Last lane before a word completes
    localparam laneT laneLast = laneT'(laneCount - 1);

    // Status flags for the bus side and the SCSI side
    typedef struct packed {
        logic wordReady;
        logic spaceReady;
        logic byteReady;
        logic byteSpace;
    } fifoStatT;

endpackage

/* src/cpuStateMachine.sv */
// Bus-master state machine
// Requests the memory bus and runs one longword cycle per FIFO word,
// and gates the SCSI handshake on FIFO space or data
module cpuStateMachine (
    input  logic                     BBCLK,
    input  logic                     CCRESET_,
    input  logic                     busy,
    input  logic                     toScsi,
    input  sdmacBusPkg::addrT        curAddr,
    input  sdmacBusPkg::countT       remaining,
    input  sdmacFifoPkg::fifoStatT   fifoStat,
    input  sdmacBusPkg::longT        fifoRdWord,
    output logic                     busReq,
    output sdmacBusPkg::memReqT      memReq,
    input  sdmacBusPkg::memRspT      memRsp,
    output logic                     wordDone,
    output sdmacBusPkg::longT        fifoWrWord,
    output logic                     scsiAck
);

    sdmacBusPkg::busStateT state;
    sdmacBusPkg::busStateT stateNext;
    logic wordCanMove;

    // A longword can move when work is left and the FIFO side allows it
    // Reading memory needs a free slot, writing memory needs a full word
    assign wordCanMove = busy && (remaining != '0) &&
                         (toScsi ? fifoStat.spaceReady : fifoStat.wordReady);

    // Next state
    always_comb begin
        stateNext = state;
        case (state)
            sdmacBusPkg::idle: begin
                if (wordCanMove) begin
                    stateNext = sdmacBusPkg::request;
                end
            end
            sdmacBusPkg::request: begin
                // Stay here until the arbiter grants the bus
                if (memRsp.busGrant) begin
                    stateNext = sdmacBusPkg::strobe;
                end
            end
            sdmacBusPkg::strobe: begin
                // Cycle length set by the slave
                if (memRsp.termAck) begin
                    stateNext = sdmacBusPkg::advance;
                end
            end
            sdmacBusPkg::advance: begin
                stateNext = sdmacBusPkg::idle;
            end
            default: begin
                stateNext = sdmacBusPkg::idle;
            end
        endcase
    end

    always_ff @(posedge BBCLK or negedge CCRESET_) begin
        if (!CCRESET_) begin
            state <= sdmacBusPkg::idle;
        end else begin
            state <= stateNext;
        end
    end

    // Read data captured with the terminate, written to the FIFO in advance
    always_ff @(posedge BBCLK) begin
        if ((state == sdmacBusPkg::strobe) && memRsp.termAck && toScsi) begin
            fifoWrWord <= memRsp.rdata;
        end
    end

    // Bus request held through grant wait and strobe, dropped in advance
    assign busReq = (state == sdmacBusPkg::request) || (state == sdmacBusPkg::strobe);

    // Address and data stay put during the strobe
    // curAddr only moves on wordDone, and the head word only on wordDone
    assign memReq.addrStrobe = (state == sdmacBusPkg::strobe);
    assign memReq.write      = !toScsi;
    assign memReq.addr       = curAddr;
    assign memReq.wdata      = fifoRdWord;

    // One pulse per finished longword
    assign wordDone = (state == sdmacBusPkg::advance);

    // SCSI side handshake
    assign scsiAck = busy && (toScsi ? fifoStat.byteReady : fifoStat.byteSpace);

endmodule

/* src/fifoPointers.sv */
// FIFO pointer counters
// Word pointers, byte-lane counters and longword occupancy,
// with the status flags derived from them
module fifoPointers (
    input  logic                   BBCLK,
    input  logic                   CCRESET_,
    input  logic                   toScsi,
    input  logic                   byteMove,
    input  logic                   wordDone,
    output sdmacFifoPkg::ptrT      wrPtr,
    output sdmacFifoPkg::ptrT      rdPtr,
    output sdmacFifoPkg::laneT     wrLane,
    output sdmacFifoPkg::laneT     rdLane,
    output sdmacFifoPkg::fifoStatT fifoStat,
    output logic                   fifoEmpty
);

    sdmacFifoPkg::occT occ;
    logic byteWr;
    logic byteRd;
    logic wordWr;
    logic wordRd;
    logic wrWrap;
    logic rdWrap;
    logic occInc;
    logic occDec;

    // SCSI side moves bytes, bus side moves whole words
    assign byteWr = byteMove && !toScsi;
    assign byteRd = byteMove && toScsi;
    assign wordWr = wordDone && toScsi;
    assign wordRd = wordDone && !toScsi;

    // Last lane done, word slot completes
    assign wrWrap = byteWr && (wrLane == sdmacFifoPkg::laneLast);
    assign rdWrap = byteRd && (rdLane == sdmacFifoPkg::laneLast);

    assign occInc = wrWrap || wordWr;
    assign occDec = rdWrap || wordRd;

    always_ff @(posedge BBCLK or negedge CCRESET_) begin
        if (!CCRESET_) begin
            wrPtr  <= '0;
            rdPtr  <= '0;
            wrLane <= '0;
            rdLane <= '0;
            occ    <= '0;
        end else begin
            if (byteWr) begin
                wrLane <= wrLane + 1'b1;
            end
            if (byteRd) begin
                rdLane <= rdLane + 1'b1;
            end
            // Pointers wrap naturally at the depth
            if (occInc) begin
                wrPtr <= wrPtr + 1'b1;
            end
            if (occDec) begin
                rdPtr <= rdPtr + 1'b1;
            end
            case ({occInc, occDec})
                2'b10: occ <= occ + 1'b1;
                2'b01: occ <= occ - 1'b1;
                default: occ <= occ;
            endcase
        end
    end

    // Head word counts as held until its last byte leaves
    assign fifoStat.wordReady  = (occ != '0);
    assign fifoStat.spaceReady = (occ != sdmacFifoPkg::occFull);
    assign fifoStat.byteReady  = (occ != '0);
    assign fifoStat.byteSpace  = (occ != sdmacFifoPkg::occFull);

    // No whole words and no partly moved word
    assign fifoEmpty = (occ == '0) && (wrLane == rdLane);

endmodule

/* src/dmaFifo.sv */
// FIFO storage
// Eight longwords split into byte lanes, byte access from SCSI,
// whole-word access from the memory bus
module dmaFifo (
    input  logic                 BBCLK,
    input  logic                 toScsi,
    input  logic                 byteMove,
    input  logic                 wordDone,
    input  sdmacFifoPkg::ptrT    wrPtr,
    input  sdmacFifoPkg::ptrT    rdPtr,
    input  sdmacFifoPkg::laneT   wrLane,
    input  sdmacFifoPkg::laneT   rdLane,
    input  sdmacFifoPkg::byteT   scsiDataIn,
    input  sdmacBusPkg::longT    fifoWrWord,
    output sdmacFifoPkg::byteT   scsiDataOut,
    output sdmacBusPkg::longT    fifoRdWord
);

    // Each slot holds four lanes, lane 0 in the low byte
    sdmacFifoPkg::byteT [sdmacFifoPkg::laneCount-1:0] fifoMem [sdmacFifoPkg::fifoDepth];

    always_ff @(posedge BBCLK) begin
        if (toScsi) begin
            // Memory to SCSI, bus fills a whole slot
            if (wordDone) begin
                fifoMem[wrPtr] <= fifoWrWord;
            end
        end else begin
            // SCSI to memory, one lane per handshake
            if (byteMove) begin
                fifoMem[wrPtr][wrLane] <= scsiDataIn;
            end
        end
    end

    // Head byte for the SCSI side
    assign scsiDataOut = fifoMem[rdPtr][rdLane];
    // Head word for the memory write
    assign fifoRdWord  = fifoMem[rdPtr];

endmodule

/* src/dmaRegs.sv */
// DMA register block
// Zero-wait APB slave for address, length, control and status,
// plus the running address and remaining-count counters
module dmaRegs (
    input  logic                BBCLK,
    input  logic                CCRESET_,
    input  sdmacBusPkg::apbReqT apbReq,
    output sdmacBusPkg::longT   prdata,
    input  logic                wordDone,
    input  logic                fifoEmpty,
    output logic                busy,
    output logic                toScsi,
    output sdmacBusPkg::addrT   curAddr,
    output sdmacBusPkg::countT  remaining
);

    sdmacBusPkg::addrT  startAddr;
    sdmacBusPkg::countT lenReg;
    logic done;
    logic apbAccess;
    logic apbWrite;
    logic ctrlWrite;
    logic startReq;
    logic lastWord;
    logic xferEnd;

    // Access phase of the APB transfer
    assign apbAccess = apbReq.psel && apbReq.penable;
    assign apbWrite  = apbAccess && apbReq.pwrite;

    // Control writes are dropped while a transfer runs
    assign ctrlWrite = apbWrite && (apbReq.paddr == sdmacBusPkg::regCtrl) && !busy;
    assign startReq  = ctrlWrite && apbReq.pwdata[sdmacBusPkg::ctrlStart];

    // SCSI to memory ends with the last bus word
    // Memory to SCSI ends once the FIFO has drained
    assign lastWord = wordDone && (remaining == sdmacBusPkg::countT'(1));
    assign xferEnd  = busy && ((!toScsi && lastWord) || ((remaining == '0) && fifoEmpty));

    // Setup registers
    always_ff @(posedge BBCLK or negedge CCRESET_) begin
        if (!CCRESET_) begin
            startAddr <= '0;
            lenReg    <= '0;
            toScsi    <= 1'b0;
        end else begin
            if (apbWrite && (apbReq.paddr == sdmacBusPkg::regAddr)) begin
                startAddr <= apbReq.pwdata[31:2];
            end
            if (apbWrite && (apbReq.paddr == sdmacBusPkg::regCount)) begin
                lenReg <= apbReq.pwdata[15:0];
            end
            if (ctrlWrite) begin
                toScsi <= apbReq.pwdata[sdmacBusPkg::ctrlDir];
            end
        end
    end

    // Transfer status and counters
    always_ff @(posedge BBCLK or negedge CCRESET_) begin
        if (!CCRESET_) begin
            busy      <= 1'b0;
            done      <= 1'b0;
            curAddr   <= '0;
            remaining <= '0;
        end else if (startReq) begin
            busy      <= 1'b1;
            done      <= 1'b0;
            curAddr   <= startAddr;
            remaining <= lenReg;
        end else begin
            if (wordDone) begin
                curAddr   <= curAddr + 1'b1;
                remaining <= remaining - 1'b1;
            end
            if (xferEnd) begin
                busy <= 1'b0;
                done <= 1'b1;
            end
        end
    end

    // Read mux, valid in the access phase
    always_comb begin
        prdata = '0;
        if (apbAccess) begin
            case (apbReq.paddr)
                sdmacBusPkg::regAddr:   prdata = {startAddr, 2'b00};
                sdmacBusPkg::regCount:  prdata = {16'h0000, lenReg};
                // Start always reads back as zero
                sdmacBusPkg::regCtrl:   prdata = {30'h0, toScsi, 1'b0};
                sdmacBusPkg::regStatus: prdata = {remaining, 14'h0, done, busy};
                default:                prdata = '0;
            endcase
        end
    end

endmodule

/* src/sdmacTop.sv */
// SCSI DMA controller top
// Registers, bus master, FIFO pointers and FIFO storage wired together
module sdmacTop (
    input  logic                 BBCLK,
    input  logic                 CCRESET_,
    input  sdmacBusPkg::apbReqT  apbReq,
    output sdmacBusPkg::longT    prdata,
    input  logic                 scsiReq,
    input  sdmacFifoPkg::byteT   scsiDataIn,
    output sdmacFifoPkg::byteT   scsiDataOut,
    output logic                 scsiAck,
    output logic                 busReq,
    output sdmacBusPkg::memReqT  memReq,
    input  sdmacBusPkg::memRspT  memRsp
);

    logic wordDone;
    logic fifoEmpty;
    logic busy;
    logic toScsi;
    logic byteMove;
    sdmacBusPkg::addrT      curAddr;
    sdmacBusPkg::countT     remaining;
    sdmacBusPkg::longT      fifoRdWord;
    sdmacBusPkg::longT      fifoWrWord;
    sdmacFifoPkg::fifoStatT fifoStat;
    sdmacFifoPkg::ptrT      wrPtr;
    sdmacFifoPkg::ptrT      rdPtr;
    sdmacFifoPkg::laneT     wrLane;
    sdmacFifoPkg::laneT     rdLane;

    // One byte per completed SCSI handshake
    assign byteMove = scsiReq && scsiAck;

    dmaRegs regs0 (
        .BBCLK, .CCRESET_, .apbReq, .prdata, .wordDone, .fifoEmpty,
        .busy, .toScsi, .curAddr, .remaining
    );

    cpuStateMachine cpuSm0 (
        .BBCLK, .CCRESET_, .busy, .toScsi, .curAddr, .remaining, .fifoStat,
        .fifoRdWord, .busReq, .memReq, .memRsp, .wordDone, .fifoWrWord, .scsiAck
    );

    fifoPointers ptrs0 (
        .BBCLK, .CCRESET_, .toScsi, .byteMove, .wordDone,
        .wrPtr, .rdPtr, .wrLane, .rdLane, .fifoStat, .fifoEmpty
    );

    dmaFifo fifo0 (
        .BBCLK, .toScsi, .byteMove, .wordDone, .wrPtr, .rdPtr, .wrLane, .rdLane,
        .scsiDataIn, .fifoWrWord, .scsiDataOut, .fifoRdWord
    );

endmodule

/* testbench/sdmacMemSlave.sv */
// Memory bus slave model
// Grants the bus and terminates cycles after programmable delays,
// backed by 256 longwords that the testbench can load
module sdmacMemSlave (
    input  logic                BBCLK,
    input  logic                CCRESET_,
    input  logic                busReq,
    input  sdmacBusPkg::memReqT memReq,
    output sdmacBusPkg::memRspT memRsp,
    input  logic [2:0]          grantDelay,
    input  logic [2:0]          termDelay,
    input  logic                loadEn,
    input  logic [7:0]          loadAddr,
    input  sdmacBusPkg::longT   loadData,
    output logic                wrValid,
    output sdmacBusPkg::addrT   wrAddr,
    output sdmacBusPkg::longT   wrData
);
    timeunit 1ns;
    timeprecision 100ps;

    sdmacBusPkg::longT mem [256];
    logic [2:0] grantCnt;
    logic [2:0] termCnt;
    logic termFire;

    // Cycle ends once the strobe has waited termDelay cycles
    assign termFire = memReq.addrStrobe && !memRsp.termAck && (termCnt >= termDelay);

    always_ff @(posedge BBCLK) begin
        if (loadEn) begin
            mem[loadAddr] <= loadData;
        end else if (termFire && memReq.write) begin
            mem[memReq.addr[7:0]] <= memReq.wdata;
        end
    end

    always_ff @(posedge BBCLK or negedge CCRESET_) begin
        if (!CCRESET_) begin
            memRsp   <= '0;
            grantCnt <= '0;
            termCnt  <= '0;
            wrValid  <= 1'b0;
            wrAddr   <= '0;
            wrData   <= '0;
        end else begin
            // Grant after grantDelay cycles of request, dropped with the request
            if (!busReq) begin
                memRsp.busGrant <= 1'b0;
                grantCnt <= '0;
            end else if (!memRsp.busGrant) begin
                if (grantCnt >= grantDelay) begin
                    memRsp.busGrant <= 1'b1;
                end else begin
                    grantCnt <= grantCnt + 1'b1;
                end
            end
            memRsp.termAck <= termFire;
            wrValid <= termFire && memReq.write;
            if (termFire) begin
                termCnt <= '0;
                memRsp.rdata <= mem[memReq.addr[7:0]];
                wrAddr <= memReq.addr;
                wrData <= memReq.wdata;
            end else if (memReq.addrStrobe && !memRsp.termAck) begin
                termCnt <= termCnt + 1'b1;
            end else begin
                termCnt <= '0;
            end
        end
    end

endmodule

/* testbench/sdmacTb.sv */
// SCSI DMA testbench
// Random transfers in both directions against a byte queue and memory model
module sdmacTb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int numXfers = 8;

    logic BBCLK;
    logic CCRESET_;
    sdmacBusPkg::apbReqT apbReq;
    sdmacBusPkg::longT prdata;
    logic scsiReq;
    sdmacFifoPkg::byteT scsiDataIn;
    sdmacFifoPkg::byteT scsiDataOut;
    logic scsiAck;
    logic busReq;
    sdmacBusPkg::memReqT memReq;
    sdmacBusPkg::memRspT memRsp;
    logic [2:0] grantDelay;
    logic [2:0] termDelay;
    logic loadEn;
    logic [7:0] loadAddr;
    sdmacBusPkg::longT loadData;
    logic wrValid;
    sdmacBusPkg::addrT wrAddr;
    sdmacBusPkg::longT wrData;

    logic [15:0] lfsr = 16'd22139;
    int xferBase [numXfers];
    int xferLen [numXfers];
    int cycles = 0;
    int cycleLimit = 2000;
    // Transfer model
    sdmacFifoPkg::byteT txBytes [$];
    sdmacFifoPkg::byteT expBytes [$];
    sdmacBusPkg::longT expMem [256];
    int writeCount [256];
    int base;
    int len;
    int totalBytes = 0;
    int moveCount = 0;
    int seenCount = 0;
    int termCount = 0;
    int seenTerm = 0;
    int stall = 0;
    logic dirToScsi = 1'b0;
    logic xferActive = 1'b0;
    logic scsiHold = 1'b0;
    sdmacBusPkg::addrT nextAddr = '0;
    // Bus values from the previous falling edge
    logic strobePrev = 1'b0;
    logic grantPrev = 1'b0;
    sdmacBusPkg::addrT addrPrev = '0;
    sdmacBusPkg::longT wdataPrev = '0;

    sdmacTop dut0 (
        .BBCLK, .CCRESET_, .apbReq, .prdata, .scsiReq, .scsiDataIn, .scsiDataOut,
        .scsiAck, .busReq, .memReq, .memRsp
    );

    sdmacMemSlave mem0 (
        .BBCLK, .CCRESET_, .busReq, .memReq, .memRsp, .grantDelay, .termDelay,
        .loadEn, .loadAddr, .loadData, .wrValid, .wrAddr, .wrData
    );

    // Galois LFSR, one step per bit taken
    function automatic logic [31:0] randBits(input int n);
        logic [31:0] r;
        r = '0;
        for (int k = 0; k < n; k++) begin
            r = {r[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
        end
        return r;
    endfunction

    task automatic stopRun();
        $display("tests failed");
        $fatal(1);
    endtask

    task automatic failValue(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        $display("Fail %s got 0x%08h expected 0x%08h", name, got, exp);
        stopRun();
    endtask

    task automatic failText(input string msg);
        $display("%s", msg);
        stopRun();
    endtask

    initial begin
        BBCLK = 1'b0;
        forever #50 BBCLK = ~BBCLK;
    end

    always @(posedge BBCLK) begin
        cycles++;
        if (cycles > cycleLimit) begin
            $display("Timeout after %0d cycles", cycles);
            stopRun();
        end
    end

    task automatic apbWrite(input sdmacBusPkg::regAddrT a, input sdmacBusPkg::longT d);
        sdmacBusPkg::apbReqT req;
        req = '0;
        req.psel = 1'b1;
        req.pwrite = 1'b1;
        req.paddr = a;
        req.pwdata = d;
        @(posedge BBCLK);
        apbReq <= req;
        req.penable = 1'b1;
        @(posedge BBCLK);
        apbReq <= req;
        @(posedge BBCLK);
        apbReq <= '0;
    endtask

    task automatic apbRead(input sdmacBusPkg::regAddrT a, output sdmacBusPkg::longT d);
        sdmacBusPkg::apbReqT req;
        req = '0;
        req.psel = 1'b1;
        req.paddr = a;
        @(posedge BBCLK);
        apbReq <= req;
        req.penable = 1'b1;
        @(posedge BBCLK);
        apbReq <= req;
        // prdata is combinational in the access phase
        @(negedge BBCLK);
        d = prdata;
        @(posedge BBCLK);
        apbReq <= '0;
    endtask

    // SCSI peripheral and bus delay source
    always @(posedge BBCLK) begin
        if (moveCount != seenCount) begin
            seenCount = moveCount;
            // Mostly short stalls, now and then a long stretch
            stall = (randBits(3) == 0) ? int'(randBits(4)) : int'(randBits(2));
        end
        if (termCount != seenTerm) begin
            seenTerm = termCount;
            grantDelay <= 3'(randBits(3));
            termDelay <= 3'(randBits(3));
        end
        // A reading peripheral keeps asking after its last byte
        // so a surplus byte from the FIFO would be taken and seen
        if (stall > 0) begin
            stall--;
            scsiReq <= 1'b0;
        end else if (xferActive && !scsiHold &&
                     (dirToScsi || (moveCount < totalBytes))) begin
            scsiReq <= 1'b1;
            if (!dirToScsi) begin
                scsiDataIn <= txBytes[moveCount];
            end
        end else begin
            scsiReq <= 1'b0;
        end
    end

    // Monitor, samples between rising edges
    always @(negedge BBCLK) begin
        if (CCRESET_) begin
            if (scsiReq && scsiAck) begin
                if (dirToScsi) begin
                    assert (expBytes.size() > 0) else failText("Extra byte sent to SCSI");
                    assert (scsiDataOut == expBytes[0])
                        else failValue("scsiDataOut", scsiDataOut, expBytes[0]);
                    void'(expBytes.pop_front());
                end
                moveCount++;
            end
            if (memReq.addrStrobe && !strobePrev) begin
                assert (grantPrev) else failText("Strobe rose without a bus grant");
                assert (memReq.addr == nextAddr) else failValue("addr", memReq.addr, nextAddr);
                assert (memReq.write == !dirToScsi)
                    else failValue("write", memReq.write, !dirToScsi);
            end
            if (memReq.addrStrobe && strobePrev) begin
                assert (memReq.addr == addrPrev) else failValue("addr", memReq.addr, addrPrev);
                assert (!memReq.write || (memReq.wdata == wdataPrev))
                    else failValue("wdata", memReq.wdata, wdataPrev);
            end
            if (memReq.addrStrobe && memRsp.termAck) begin
                nextAddr++;
                termCount++;
            end
            if (wrValid) begin
                assert (!dirToScsi) else failText("Memory written during a read transfer");
                assert ((wrAddr >= base) && (wrAddr < base + len))
                    else failValue("wrAddr", wrAddr, base);
                assert (writeCount[wrAddr[7:0]] == 0) else failText("Longword written twice");
                assert (wrData == expMem[wrAddr[7:0]])
                    else failValue("wdata", wrData, expMem[wrAddr[7:0]]);
                writeCount[wrAddr[7:0]]++;
            end
            strobePrev = memReq.addrStrobe;
            grantPrev = memRsp.busGrant;
            addrPrev = memReq.addr;
            wdataPrev = memReq.wdata;
        end
    end

    task automatic runTransfer(input int idx);
        sdmacBusPkg::longT w;
        sdmacBusPkg::longT s;
        int prevRem;
        // Data words drawn at a falling edge, clear of the peripheral's draws
        @(negedge BBCLK);
        base = xferBase[idx];
        len = xferLen[idx];
        dirToScsi = idx[0];
        txBytes.delete();
        expBytes.delete();
        for (int a = 0; a < 256; a++) begin
            writeCount[a] = 0;
        end
        moveCount = 0;
        totalBytes = len * 4;
        nextAddr = sdmacBusPkg::addrT'(base);
        for (int k = 0; k < len; k++) begin
            w = randBits(32);
            expMem[base + k] = w;
            for (int b = 0; b < 4; b++) begin
                if (dirToScsi) begin
                    expBytes.push_back(w[8*b +: 8]);
                end else begin
                    txBytes.push_back(w[8*b +: 8]);
                end
            end
        end
        if (dirToScsi) begin
            for (int k = 0; k < len; k++) begin
                @(posedge BBCLK);
                loadEn <= 1'b1;
                loadAddr <= 8'(base + k);
                loadData <= expMem[base + k];
            end
        end
        @(posedge BBCLK);
        loadEn <= 1'b0;
        scsiHold <= 1'b1;
        apbWrite(sdmacBusPkg::regAddr, 32'(base) << 2);
        apbWrite(sdmacBusPkg::regCount, 32'(len));
        xferActive <= 1'b1;
        apbWrite(sdmacBusPkg::regCtrl, {30'h0, dirToScsi, 1'b1});
        // SCSI side held, so the transfer cannot end under a second start
        apbWrite(sdmacBusPkg::regAddr, 32'((base + 100) % 256) << 2);
        apbWrite(sdmacBusPkg::regCtrl, {30'h0, !dirToScsi, 1'b1});
        scsiHold <= 1'b0;
        prevRem = len;
        apbRead(sdmacBusPkg::regStatus, s);
        while (!s[1]) begin
            assert (s[0]) else failValue("busy", s[0], 1);
            assert (s[31:16] <= prevRem) else failValue("remaining", s[31:16], prevRem);
            prevRem = s[31:16];
            apbRead(sdmacBusPkg::regStatus, s);
        end
        assert (!s[0]) else failValue("busy", s[0], 0);
        assert (s[31:16] == 0) else failValue("remaining", s[31:16], 0);
        xferActive <= 1'b0;
        assert (moveCount == totalBytes) else failValue("byte count", moveCount, totalBytes);
        if (!dirToScsi) begin
            for (int k = 0; k < len; k++) begin
                assert (writeCount[base + k] == 1) else failText("Longword never written");
            end
        end
    endtask

    initial begin
        sdmacBusPkg::longT d;
        sdmacBusPkg::longT v;
        CCRESET_ = 1'b0;
        apbReq = '0;
        scsiReq = 1'b0;
        scsiDataIn = '0;
        grantDelay = '0;
        termDelay = '0;
        loadEn = 1'b0;
        loadAddr = '0;
        loadData = '0;
        for (int i = 0; i < numXfers; i++) begin
            xferBase[i] = randBits(7);
            xferLen[i] = randBits(4) % 12 + 1;
            cycleLimit += 64 * xferLen[i];
        end
        repeat (10) @(posedge BBCLK);
        CCRESET_ <= 1'b1;
        @(negedge BBCLK);
        assert (!busReq) else failValue("busReq", busReq, 0);
        assert (!memReq.addrStrobe) else failValue("addrStrobe", memReq.addrStrobe, 0);
        assert (!scsiAck) else failValue("scsiAck", scsiAck, 0);
        apbRead(sdmacBusPkg::regStatus, d);
        assert (d[1:0] == 2'b00) else failValue("status", d, 0);
        v = {30'(randBits(30)), 2'b00};
        apbWrite(sdmacBusPkg::regAddr, v);
        apbRead(sdmacBusPkg::regAddr, d);
        assert (d == v) else failValue("regAddr", d, v);
        v = {16'h0, 16'(randBits(16))};
        apbWrite(sdmacBusPkg::regCount, v);
        apbRead(sdmacBusPkg::regCount, d);
        assert (d == v) else failValue("regCount", d, v);
        for (int i = 0; i < numXfers; i++) begin
            runTransfer(i);
        end
        $display("all tests passed");
        $finish;
    end

endmodule

/* build.f */
src/sdmacBusPkg.sv
src/sdmacFifoPkg.sv
src/cpuStateMachine.sv
src/fifoPointers.sv
src/dmaFifo.sv
src/dmaRegs.sv
src/sdmacTop.sv
testbench/sdmacMemSlave.sv
testbench/sdmacTb.sv

/* Makefile */
VERILATOR ?= verilator
FLAGS     ?= --binary --timing -j 0
LINTFLAGS ?= --lint-only --timing
TOP       ?= sdmacTb
FILELIST  ?= build.f
OBJDIR    ?= obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

$(OBJDIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

sim: $(OBJDIR)/V$(TOP)
	./$(OBJDIR)/V$(TOP)

clean:
	rm -rf $(OBJDIR)
